/* design/exePkg.sv */
package exePkg;

    // widths with a meaning
    typedef logic [31:0] word_t;     // data, address or immediate
    typedef logic [4:0]  regAddr_t;  // destination register index
    typedef logic [1:0]  pcSel_t;    // next-pc source, used by fetch
    typedef logic [2:0]  funct_t;    // writeback function code

    // ALU ops, low bits follow funct3, bit 3 marks sub/sra
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOp_t;

    // M-extension ops, same order as funct3
    typedef enum logic [2:0] {
        opMul    = 3'd0,
        opMulh   = 3'd1,
        opMulhsu = 3'd2,
        opMulhu  = 3'd3,
        opDiv    = 3'd4,
        opDivu   = 3'd5,
        opRem    = 3'd6,
        opRemu   = 3'd7
    } mulOp_t;

    typedef enum logic [3:0] {
        memNone = 4'd0,
        memLb   = 4'd1,
        memLh   = 4'd2,
        memLw   = 4'd3,
        memLbu  = 4'd4,
        memLhu  = 4'd5,
        memSb   = 4'd6,
        memSh   = 4'd7,
        memSw   = 4'd8
    } memOp_t;

    // control bundle carried from issue into stage 5
    typedef struct packed {
        logic     writeEn;
        logic     bneq;      // invert the zero test for the branch
        logic     btype;     // conditional branch
        funct_t   fn;
        regAddr_t rd;
        pcSel_t   pcSelect;
        logic     j;         // jal
        logic     jr;        // jalr
    } exeCtrl_t;

endpackage

/* design/alu.sv */
module alu (
    input  exePkg::aluOp_t aluOp,
    input  exePkg::word_t  operandA,
    input  exePkg::word_t  operandB,
    input  logic           bneq,
    input  logic           btype,
    output exePkg::word_t  result,
    output logic           btaken
);

    logic [4:0] shamt;
    logic       isZero;

    assign shamt = operandB[4:0];

    always_comb
    begin
        case (aluOp)
            exePkg::aluAdd:  result = operandA + operandB;
            exePkg::aluSub:  result = operandA - operandB;
            exePkg::aluSll:  result = operandA << shamt;
            exePkg::aluSrl:  result = operandA >> shamt;
            exePkg::aluSra:  result = exePkg::word_t'($signed(operandA) >>> shamt);
            exePkg::aluXor:  result = operandA ^ operandB;
            exePkg::aluOr:   result = operandA | operandB;
            exePkg::aluAnd:  result = operandA & operandB;
            exePkg::aluSlt:
            begin
                // signed compare, 1 when a < b
                result = {31'b0, $signed(operandA) < $signed(operandB)};
            end
            exePkg::aluSltu: result = {31'b0, operandA < operandB};
            default:         result = '0;
        endcase
    end

    // branch compares reuse the ALU result
    // beq/bne run sub, blt/bge/bltu/bgeu run slt or sltu
    assign isZero = (result == '0);
    assign btaken = btype & (bneq ^ isZero);

endmodule

/* design/branchUnit.sv */
module branchUnit (
    input  exePkg::word_t pc,
    input  exePkg::word_t operandA,
    input  exePkg::word_t bImm,
    input  exePkg::word_t jImm,
    input  exePkg::word_t iImm,
    input  logic          btaken,
    input  logic          j,
    input  logic          jr,
    output exePkg::word_t target
);

    exePkg::word_t jrSum;
    exePkg::word_t jrTarget;
    exePkg::word_t jTarget;
    exePkg::word_t bTarget;
    exePkg::word_t seqTarget;

    // all candidates in parallel
    assign jrSum     = operandA + iImm;
    assign jrTarget  = {jrSum[31:1], 1'b0};  // jalr drops bit 0
    assign jTarget   = pc + jImm;
    assign bTarget   = pc + bImm;
    assign seqTarget = pc + 32'd4;

    // jr over j over taken branch over fall-through
    assign target = jr     ? jrTarget :
                    j      ? jTarget  :
                    btaken ? bTarget  :
                             seqTarget;

endmodule

/* design/mulDiv.sv */
module mulDiv (
    input  exePkg::word_t  a,
    input  exePkg::word_t  b,
    input  exePkg::mulOp_t mulOp,
    output exePkg::word_t  res
);

    logic [63:0] aSx;
    logic [63:0] aZx;
    logic [63:0] bSx;
    logic [63:0] bZx;
    logic [63:0] prodSS;
    logic [63:0] prodSU;
    logic [63:0] prodUU;
    logic        divByZero;
    logic        overflow;
    logic signed [31:0] quotS;
    logic signed [31:0] remS;
    exePkg::word_t      quotU;
    exePkg::word_t      remU;

    // extend to 64 bits so the low 64 bits of each product are exact
    assign aSx = {{32{a[31]}}, a};
    assign aZx = {32'b0, a};
    assign bSx = {{32{b[31]}}, b};
    assign bZx = {32'b0, b};

    assign prodSS = aSx * bSx;
    assign prodSU = aSx * bZx;  // mulhsu, a signed and b unsigned
    assign prodUU = aZx * bZx;

    assign divByZero = (b == '0);
    assign overflow  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);

    assign quotS = $signed(a) / $signed(b);
    assign remS  = $signed(a) % $signed(b);
    assign quotU = a / b;
    assign remU  = a % b;

    always_comb
    begin
        case (mulOp)
            exePkg::opMul:    res = prodSS[31:0];
            exePkg::opMulh:   res = prodSS[63:32];
            exePkg::opMulhsu: res = prodSU[63:32];
            exePkg::opMulhu:  res = prodUU[63:32];
            exePkg::opDiv:    res = divByZero ? '1 : overflow ? a : exePkg::word_t'(quotS);
            exePkg::opDivu:   res = divByZero ? '1 : quotU;
            exePkg::opRem:    res = divByZero ? a : overflow ? '0 : exePkg::word_t'(remS);
            default:          res = divByZero ? a : remU;  // remu
        endcase
    end

endmodule

/* design/memWrap.sv */
module memWrap #(
    parameter int dmemWords = 256
) (
    input  logic           clk,
    input  logic           nrst,
    input  exePkg::memOp_t memOp4,
    input  exePkg::word_t  opA4,
    input  exePkg::word_t  opB4,   // store data, or load offset
    input  exePkg::word_t  sImm4,  // store offset
    output exePkg::word_t  memOut6,
    output logic           addrMisaligned6
);

    localparam int idxW = $clog2(dmemWords);

    exePkg::word_t   mem [dmemWords];
    logic            isStore4;
    exePkg::word_t   addr4;
    logic [idxW-1:0] idx4;
    logic            misaligned4;
    logic [3:0]      byteEn4;
    exePkg::word_t   wrData4;

    exePkg::memOp_t  opReg5;
    logic            misReg5;
    logic [idxW-1:0] idxReg5;
    logic [1:0]      laneReg5;
    exePkg::word_t   rdWord5;
    exePkg::word_t   shifted5;
    exePkg::word_t   loadData5;

    assign isStore4 = (memOp4 == exePkg::memSb) || (memOp4 == exePkg::memSh) ||
                      (memOp4 == exePkg::memSw);
    assign addr4    = isStore4 ? opA4 + sImm4 : opA4 + opB4;
    assign idx4     = addr4[idxW+1:2];  // wraps at dmemWords

    always_comb
    begin
        case (memOp4)
            exePkg::memLh, exePkg::memLhu, exePkg::memSh: misaligned4 = addr4[0];
            exePkg::memLw, exePkg::memSw:                 misaligned4 = |addr4[1:0];
            default:                                      misaligned4 = 1'b0;
        endcase
        byteEn4 = 4'b0000;
        wrData4 = opB4;
        case (memOp4)
            exePkg::memSb:
            begin
                byteEn4 = 4'b0001 << addr4[1:0];
                wrData4 = {4{opB4[7:0]}};    // replicate onto every lane
            end
            exePkg::memSh:
            begin
                byteEn4 = 4'b0011 << addr4[1:0];
                wrData4 = {2{opB4[15:0]}};
            end
            exePkg::memSw: byteEn4 = 4'b1111;
            default:       byteEn4 = 4'b0000;
        endcase
    end

    // store lands at the stage 4 to 5 edge
    always_ff @(posedge clk)
    begin
        if (nrst && !misaligned4)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byteEn4[i])
                    mem[idx4][8*i +: 8] <= wrData4[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            opReg5  <= exePkg::memNone;
            misReg5 <= 1'b0;
        end
        else
        begin
            opReg5  <= memOp4;
            misReg5 <= misaligned4;
        end
    end

    always_ff @(posedge clk)
    begin
        idxReg5  <= idx4;
        laneReg5 <= addr4[1:0];
    end

    // read, align and extend in stage 5
    assign rdWord5  = mem[idxReg5];
    assign shifted5 = rdWord5 >> {laneReg5, 3'b000};

    always_comb
    begin
        case (opReg5)
            exePkg::memLb:  loadData5 = {{24{shifted5[7]}}, shifted5[7:0]};
            exePkg::memLbu: loadData5 = {24'b0, shifted5[7:0]};
            exePkg::memLh:  loadData5 = {{16{shifted5[15]}}, shifted5[15:0]};
            exePkg::memLhu: loadData5 = {16'b0, shifted5[15:0]};
            exePkg::memLw:  loadData5 = rdWord5;
            default:        loadData5 = '0;  // stores and none
        endcase
        if (misReg5)
            loadData5 = '0;
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            memOut6         <= '0;
            addrMisaligned6 <= 1'b0;
        end
        else
        begin
            memOut6         <= loadData5;
            addrMisaligned6 <= misReg5;
        end
    end

endmodule

/* design/exeStage.sv */
module exeStage #(
    parameter int dmemWords = 256
) (
    input  logic             clk,
    input  logic             nrst,
    input  exePkg::exeCtrl_t ctrl4,
    input  exePkg::aluOp_t   aluOp4,
    input  exePkg::mulOp_t   mulOp4,
    input  exePkg::memOp_t   memOp4,
    input  exePkg::word_t    opA,
    input  exePkg::word_t    opB,
    input  exePkg::word_t    pc4,
    input  exePkg::word_t    bImm4,
    input  exePkg::word_t    jImm4,
    input  exePkg::word_t    sImm4,
    output logic             writeEn5,
    output logic             j5,
    output logic             jr5,
    output exePkg::funct_t   fn5,
    output exePkg::regAddr_t rd5,
    output exePkg::pcSel_t   pcSelect5,
    output exePkg::word_t    aluRes5,
    output exePkg::word_t    target,
    output exePkg::word_t    mulDiv5,
    output exePkg::word_t    pc5,
    output exePkg::word_t    memOut6,
    output logic             addrMisaligned6
);

    exePkg::exeCtrl_t ctrlReg5;
    exePkg::aluOp_t   aluOpReg5;
    exePkg::mulOp_t   mulOpReg5;
    exePkg::word_t    opAReg5;
    exePkg::word_t    opBReg5;
    exePkg::word_t    pcReg5;
    exePkg::word_t    bImmReg5;
    exePkg::word_t    jImmReg5;
    logic             btaken;

    // stage 5 control, cleared by reset
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            ctrlReg5  <= '0;
            aluOpReg5 <= exePkg::aluAdd;
            mulOpReg5 <= exePkg::opMul;
        end
        else
        begin
            ctrlReg5  <= ctrl4;
            aluOpReg5 <= aluOp4;
            mulOpReg5 <= mulOp4;
        end
    end

    // stage 5 payload
    always_ff @(posedge clk)
    begin
        opAReg5  <= opA;
        opBReg5  <= opB;
        pcReg5   <= pc4;
        bImmReg5 <= bImm4;
        jImmReg5 <= jImm4;
    end

    alu alu_i (
        .aluOp    (aluOpReg5),
        .operandA (opAReg5),
        .operandB (opBReg5),
        .bneq     (ctrlReg5.bneq),
        .btype    (ctrlReg5.btype),
        .result   (aluRes5),
        .btaken   (btaken)
    );

    branchUnit branch_i (
        .pc       (pcReg5),
        .operandA (opAReg5),
        .bImm     (bImmReg5),
        .jImm     (jImmReg5),
        .iImm     (opBReg5),  // jalr offset arrives on operand B
        .btaken   (btaken),
        .j        (ctrlReg5.j),
        .jr       (ctrlReg5.jr),
        .target   (target)
    );

    mulDiv mulDiv_i (
        .a     (opAReg5),
        .b     (opBReg5),
        .mulOp (mulOpReg5),
        .res   (mulDiv5)
    );

    // memory keeps its own pipe from stage 4
    memWrap #(
        .dmemWords (dmemWords)
    ) mem_i (
        .clk             (clk),
        .nrst            (nrst),
        .memOp4          (memOp4),
        .opA4            (opA),
        .opB4            (opB),
        .sImm4           (sImm4),
        .memOut6         (memOut6),
        .addrMisaligned6 (addrMisaligned6)
    );

    assign writeEn5  = ctrlReg5.writeEn;
    assign j5        = ctrlReg5.j;
    assign jr5       = ctrlReg5.jr;
    assign fn5       = ctrlReg5.fn;
    assign rd5       = ctrlReg5.rd;
    assign pcSelect5 = ctrlReg5.pcSelect;
    assign pc5       = pcReg5;

endmodule

/* verification/exeStage_assert.sv */
module exeStageAssert #(
    parameter int dmemWords = 256
) (
    input logic             clk,
    input logic             nrst,
    input exePkg::exeCtrl_t ctrl4,
    input exePkg::aluOp_t   aluOp4,
    input exePkg::mulOp_t   mulOp4,
    input exePkg::memOp_t   memOp4,
    input exePkg::word_t    opA,
    input exePkg::word_t    opB,
    input exePkg::word_t    pc4,
    input exePkg::word_t    bImm4,
    input exePkg::word_t    jImm4,
    input exePkg::word_t    sImm4,
    input logic             writeEn5,
    input logic             j5,
    input logic             jr5,
    input exePkg::funct_t   fn5,
    input exePkg::regAddr_t rd5,
    input exePkg::pcSel_t   pcSelect5,
    input exePkg::word_t    aluRes5,
    input exePkg::word_t    target,
    input exePkg::word_t    mulDiv5,
    input exePkg::word_t    pc5,
    input exePkg::word_t    memOut6,
    input logic             addrMisaligned6
);

    localparam int idxW = $clog2(dmemWords);

    int               failCount = 0;
    logic             valid1;
    logic             valid2;
    exePkg::exeCtrl_t ctrlD1;
    exePkg::aluOp_t   aluOpD1;
    exePkg::mulOp_t   mulOpD1;
    exePkg::word_t    opAD1;
    exePkg::word_t    opBD1;
    exePkg::word_t    pcD1;
    exePkg::word_t    bImmD1;
    exePkg::word_t    jImmD1;
    exePkg::word_t    modelMem [dmemWords];
    exePkg::word_t    memAddr;
    logic [idxW-1:0]  memIdx;
    logic             isStore;
    logic             isLoad;
    logic             misNow;
    exePkg::word_t    expLoad5;
    exePkg::word_t    expLoad6;
    logic             expMis5;
    logic             expMis6;
    logic             chk5;
    logic             chk6;
    exePkg::word_t    expAlu;
    exePkg::word_t    expMul;
    exePkg::word_t    expTarget;
    logic             expTaken;
    logic [12:0]      ctrlOut;
    logic [12:0]      ctrlExp;

    function automatic exePkg::word_t aluRef(exePkg::aluOp_t op, exePkg::word_t a,
                                             exePkg::word_t b);
        case (op)
            exePkg::aluAdd:  return a + b;
            exePkg::aluSub:  return a - b;
            exePkg::aluSll:  return a << b[4:0];
            exePkg::aluSrl:  return a >> b[4:0];
            exePkg::aluSra:  return exePkg::word_t'($signed(a) >>> b[4:0]);
            exePkg::aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exePkg::aluSltu: return (a < b) ? 32'd1 : 32'd0;
            exePkg::aluXor:  return a ^ b;
            exePkg::aluOr:   return a | b;
            default:         return a & b;
        endcase
    endfunction

    function automatic exePkg::word_t mulRef(exePkg::mulOp_t op, exePkg::word_t a,
                                             exePkg::word_t b);
        longint      ss;
        longint      su;
        logic [63:0] uu;
        ss = longint'($signed(a)) * longint'($signed(b));
        su = longint'($signed(a)) * longint'({32'b0, b});
        uu = {32'b0, a} * {32'b0, b};
        case (op)
            exePkg::opMul:    return ss[31:0];
            exePkg::opMulh:   return ss[63:32];
            exePkg::opMulhsu: return su[63:32];
            exePkg::opMulhu:  return uu[63:32];
            exePkg::opDiv:
            begin
                if (b == 0)
                    return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                    return a;  // overflow keeps the dividend
                return exePkg::word_t'($signed(a) / $signed(b));
            end
            exePkg::opDivu:   return (b == 0) ? 32'hffff_ffff : a / b;
            exePkg::opRem:
            begin
                if (b == 0)
                    return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                    return 32'd0;
                return exePkg::word_t'($signed(a) % $signed(b));
            end
            default:          return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic exePkg::word_t storeMerge(exePkg::memOp_t op, exePkg::word_t old,
                                                 exePkg::word_t d, logic [1:0] lane);
        exePkg::word_t r;
        r = old;
        case (op)
            exePkg::memSb: r[8*lane +: 8] = d[7:0];
            exePkg::memSh: r[8*lane +: 16] = d[15:0];
            default:       r = d;
        endcase
        return r;
    endfunction

    function automatic exePkg::word_t loadRef(exePkg::memOp_t op, exePkg::word_t w,
                                              logic [1:0] lane);
        exePkg::word_t s;
        s = w >> (8 * lane);
        case (op)
            exePkg::memLb:  return {{24{s[7]}}, s[7:0]};
            exePkg::memLbu: return {24'b0, s[7:0]};
            exePkg::memLh:  return {{16{s[15]}}, s[15:0]};
            exePkg::memLhu: return {16'b0, s[15:0]};
            default:        return w;
        endcase
    endfunction

    assign isStore = memOp4 inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
    assign isLoad  = memOp4 inside {exePkg::memLb, exePkg::memLh, exePkg::memLw,
                                    exePkg::memLbu, exePkg::memLhu};
    assign memAddr = isStore ? opA + sImm4 : opA + opB;
    assign memIdx  = memAddr[idxW+1:2];
    assign misNow  = ((memOp4 inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh})
                      && memAddr[0]) ||
                     ((memOp4 inside {exePkg::memLw, exePkg::memSw}) && memAddr[1:0] != 0);

    // stage 5 expectations from the delayed inputs
    assign expAlu    = aluRef(aluOpD1, opAD1, opBD1);
    assign expMul    = mulRef(mulOpD1, opAD1, opBD1);
    assign expTaken  = ctrlD1.btype & (ctrlD1.bneq ^ (expAlu == 32'd0));
    assign expTarget = ctrlD1.jr ? ((opAD1 + opBD1) & 32'hffff_fffe) :
                       ctrlD1.j  ? pcD1 + jImmD1 :
                       expTaken  ? pcD1 + bImmD1 : pcD1 + 32'd4;

    assign ctrlOut = {writeEn5, fn5, rd5, pcSelect5, j5, jr5};
    assign ctrlExp = {ctrlD1.writeEn, ctrlD1.fn, ctrlD1.rd, ctrlD1.pcSelect,
                      ctrlD1.j, ctrlD1.jr};

    always @(posedge clk)
    begin
        ctrlD1  <= ctrl4;
        aluOpD1 <= aluOp4;
        mulOpD1 <= mulOp4;
        opAD1   <= opA;
        opBD1   <= opB;
        pcD1    <= pc4;
        bImmD1  <= bImm4;
        jImmD1  <= jImm4;
        if (nrst && isStore && !misNow)
            modelMem[memIdx] <= storeMerge(memOp4, modelMem[memIdx], opB, memAddr[1:0]);
    end

    always @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            valid1  <= 1'b0;
            valid2  <= 1'b0;
            expMis5 <= 1'b0;
            expMis6 <= 1'b0;
            chk5    <= 1'b0;
            chk6    <= 1'b0;
        end
        else
        begin
            valid1   <= 1'b1;
            valid2   <= valid1;
            expLoad5 <= loadRef(memOp4, modelMem[memIdx], memAddr[1:0]);  // sees older stores
            expMis5  <= misNow;
            chk5     <= isLoad && !misNow;
            expLoad6 <= expLoad5;
            expMis6  <= expMis5;
            chk6     <= chk5;
        end
    end

    aResetCtrl: assert property (@(posedge clk)
        !valid1 |-> {writeEn5, j5, jr5, pcSelect5} == 5'b0)
    else
    begin
        failCount++;
        $error("mismatch at %0t: writeEn5/j5/jr5/pcSelect5 got %b %b %b %b expected 0 0 0 0",
               $time, $sampled(writeEn5), $sampled(j5), $sampled(jr5), $sampled(pcSelect5));
    end

    aResetMem: assert property (@(posedge clk)
        !valid2 |-> memOut6 == 32'd0 && !addrMisaligned6)
    else
    begin
        failCount++;
        $error("mismatch at %0t: memOut6 got %h expected 0, addrMisaligned6 got %b expected 0",
               $time, $sampled(memOut6), $sampled(addrMisaligned6));
    end

    aAlu: assert property (@(posedge clk) valid1 |-> aluRes5 == expAlu)
    else
    begin
        failCount++;
        $error("mismatch at %0t: aluRes5 got %h expected %h", $time,
               $sampled(aluRes5), $sampled(expAlu));
    end

    aCtrl: assert property (@(posedge clk) valid1 |-> ctrlOut == ctrlExp)
    else
    begin
        failCount++;
        $error("mismatch at %0t: writeEn5/fn5/rd5/pcSelect5/j5/jr5 got %b expected %b",
               $time, $sampled(ctrlOut), $sampled(ctrlExp));
    end

    aPc: assert property (@(posedge clk) valid1 |-> pc5 == pcD1)
    else
    begin
        failCount++;
        $error("mismatch at %0t: pc5 got %h expected %h", $time,
               $sampled(pc5), $sampled(pcD1));
    end

    aTarget: assert property (@(posedge clk) valid1 |-> target == expTarget)
    else
    begin
        failCount++;
        $error("mismatch at %0t: target got %h expected %h", $time,
               $sampled(target), $sampled(expTarget));
    end

    aMulDiv: assert property (@(posedge clk) valid1 |-> mulDiv5 == expMul)
    else
    begin
        failCount++;
        $error("mismatch at %0t: mulDiv5 got %h expected %h", $time,
               $sampled(mulDiv5), $sampled(expMul));
    end

    aMis: assert property (@(posedge clk) valid2 |-> addrMisaligned6 == expMis6)
    else
    begin
        failCount++;
        $error("mismatch at %0t: addrMisaligned6 got %b expected %b", $time,
               $sampled(addrMisaligned6), $sampled(expMis6));
    end

    aLoad: assert property (@(posedge clk) valid2 && chk6 |-> memOut6 == expLoad6)
    else
    begin
        failCount++;
        $error("mismatch at %0t: memOut6 got %h expected %h", $time,
               $sampled(memOut6), $sampled(expLoad6));
    end

endmodule

bind exeStage exeStageAssert #(.dmemWords(dmemWords)) chk_i (.*);

/* verification/exeStageTb.sv */
module exeStageTb;

    localparam int dmemWords  = 256;
    localparam int stimCycles = 460;  // all tests summed and rounded up
    localparam int cycleLimit = 2 * stimCycles + 50;

    logic             clk;
    logic             nrst;
    exePkg::exeCtrl_t ctrl4;
    exePkg::aluOp_t   aluOp4;
    exePkg::mulOp_t   mulOp4;
    exePkg::memOp_t   memOp4;
    exePkg::word_t    opA;
    exePkg::word_t    opB;
    exePkg::word_t    pc4;
    exePkg::word_t    bImm4;
    exePkg::word_t    jImm4;
    exePkg::word_t    sImm4;
    logic             writeEn5;
    logic             j5;
    logic             jr5;
    exePkg::funct_t   fn5;
    exePkg::regAddr_t rd5;
    exePkg::pcSel_t   pcSelect5;
    exePkg::word_t    aluRes5;
    exePkg::word_t    target;
    exePkg::word_t    mulDiv5;
    exePkg::word_t    pc5;
    exePkg::word_t    memOut6;
    logic             addrMisaligned6;

    int cycles = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int startFails = 0;
    exePkg::aluOp_t aluOps [10];
    exePkg::memOp_t stOps [3];
    exePkg::memOp_t ldOps [5];

    exeStage #(
        .dmemWords (dmemWords)
    ) dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("timeout, run went past %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic setIdle();
        ctrl4  = '0;
        aluOp4 = exePkg::aluAdd;
        mulOp4 = exePkg::opMul;
        memOp4 = exePkg::memNone;
        opA    = '0;
        opB    = '0;
        pc4    = '0;
        bImm4  = '0;
        jImm4  = '0;
        sImm4  = '0;
    endtask

    task automatic endTest(string name);
        int errs;
        nextCycle();
        setIdle();
        nextCycle();  // let the last item reach stage 6
        nextCycle();
        errs = dut_i.chk_i.failCount - startFails;
        testsRun++;
        if (errs != 0)
            testsFailed++;
        $display("test %s: %s, %0d assertion failures", name, errs ? "fail" : "pass", errs);
        startFails = dut_i.chk_i.failCount;
    endtask

    task automatic issueMem(exePkg::memOp_t op, exePkg::word_t addr, exePkg::word_t data);
        exePkg::word_t off;
        off = $urandom % 64;
        nextCycle();
        setIdle();
        memOp4 = op;
        opA    = addr - off;
        if (op inside {exePkg::memSb, exePkg::memSh, exePkg::memSw})
        begin
            sImm4 = off;
            opB   = data;
        end
        else
            opB = off;
    endtask

    task automatic issueBranch(exePkg::aluOp_t op, logic neq, exePkg::word_t a,
                               exePkg::word_t b);
        nextCycle();
        setIdle();
        ctrl4.btype = 1'b1;
        ctrl4.bneq  = neq;
        aluOp4      = op;
        opA         = a;
        opB         = b;
        pc4         = $urandom & 32'hffff_fffc;
        bImm4       = 32'h0000_0040;
    endtask

    task automatic resetTest();
        issueMem(exePkg::memLw, 32'h8, 32'd0);  // nonzero word in flight
        nextCycle();
        setIdle();
        nextCycle();  // load data now sits on memOut6
        nrst           = 1'b0;
        ctrl4          = exePkg::exeCtrl_t'($urandom);
        ctrl4.writeEn  = 1'b1;
        ctrl4.j        = 1'b1;
        ctrl4.jr       = 1'b1;
        ctrl4.pcSelect = 2'b11;
        memOp4         = exePkg::memSw;  // must not land while in reset
        opA            = 32'h8;
        opB            = 32'hdead_beef;
        repeat (10) nextCycle();
        nrst = 1'b1;
        setIdle();
        issueMem(exePkg::memLw, 32'h8, 32'd0);
        endTest("reset");
    endtask

    task automatic aluTest();
        repeat (40)
        begin
            nextCycle();
            ctrl4  = exePkg::exeCtrl_t'($urandom);
            aluOp4 = aluOps[$urandom % 10];
            mulOp4 = exePkg::mulOp_t'($urandom % 8);
            opA    = $urandom;
            opB    = $urandom;
            pc4    = $urandom;
            bImm4  = $urandom;
            jImm4  = $urandom;
        end
        endTest("alu");
    endtask

    task automatic branchTest();
        exePkg::aluOp_t brOp [6];
        logic           brNeq [6];
        exePkg::word_t  aVal [3];
        exePkg::word_t  bVal [3];
        brOp  = '{exePkg::aluSub, exePkg::aluSub, exePkg::aluSlt, exePkg::aluSlt,
                  exePkg::aluSltu, exePkg::aluSltu};
        brNeq = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};  // beq bne blt bge bltu bgeu
        aVal  = '{32'd5, 32'hffff_fff0, 32'd3};  // equal, less, greater (signed)
        bVal  = '{32'd5, 32'd3, 32'hffff_fff0};
        for (int k = 0; k < 6; k++)
            for (int r = 0; r < 3; r++)
                issueBranch(brOp[k], brNeq[k], aVal[r], bVal[r]);
        nextCycle();
        setIdle();
        ctrl4.j = 1'b1;
        pc4     = 32'h0000_1000;
        jImm4   = 32'h0000_0800;
        nextCycle();
        setIdle();
        ctrl4.jr = 1'b1;
        opA      = 32'h0000_1001;  // odd sum so bit 0 gets cleared
        opB      = 32'h0000_0020;
        nextCycle();
        setIdle();
        aluOp4 = exePkg::aluSub;
        pc4    = 32'h0000_2000;
        endTest("branch");
    endtask

    task automatic mulDivTest();
        repeat (30)
        begin
            nextCycle();
            setIdle();
            mulOp4 = exePkg::mulOp_t'($urandom % 4);
            opA    = $urandom;
            opB    = $urandom;
        end
        for (int k = 4; k < 8; k++)
        begin
            nextCycle();
            setIdle();
            mulOp4 = exePkg::mulOp_t'(k);
            opA    = $urandom;  // divide by zero
        end
        for (int k = 4; k < 8; k += 2)
        begin
            nextCycle();
            setIdle();
            mulOp4 = exePkg::mulOp_t'(k);
            opA    = 32'h8000_0000;
            opB    = 32'hffff_ffff;
        end
        repeat (10)
        begin
            nextCycle();
            setIdle();
            mulOp4 = exePkg::mulOp_t'(4 + $urandom % 4);
            opA    = $urandom;
            opB    = $urandom % 1000 + 1;
        end
        endTest("muldiv");
    endtask

    task automatic memTest();
        exePkg::memOp_t st;
        exePkg::memOp_t ld;
        exePkg::word_t  addr;
        logic [1:0]     lane;
        for (int i = 0; i < 20; i++)
        begin
            st   = stOps[i % 3];
            ld   = ldOps[i % 5];
            lane = 2'($urandom);
            if (st == exePkg::memSw || ld == exePkg::memLw)
                lane = 2'b00;
            else if (st == exePkg::memSh || ld inside {exePkg::memLh, exePkg::memLhu})
                lane[0] = 1'b0;
            addr = ($urandom & 32'h0000_03fc) | {30'b0, lane};
            issueMem(st, addr, $urandom);
            issueMem(ld, addr, 32'd0);
        end
        endTest("memory");
    endtask

    task automatic misalignTest();
        issueMem(exePkg::memSw, 32'h21, 32'h1111_1111);
        issueMem(exePkg::memSh, 32'h25, 32'h2222_2222);
        issueMem(exePkg::memLh, 32'h27, 32'd0);
        issueMem(exePkg::memLw, 32'h2a, 32'd0);
        issueMem(exePkg::memLhu, 32'h31, 32'd0);
        issueMem(exePkg::memLw, 32'h20, 32'd0);  // untouched by the bad stores
        issueMem(exePkg::memLw, 32'h24, 32'd0);
        endTest("misaligned");
    endtask

    initial
    begin
        void'($urandom(98));
        aluOps = '{exePkg::aluAdd, exePkg::aluSub, exePkg::aluSll, exePkg::aluSlt,
                   exePkg::aluSltu, exePkg::aluXor, exePkg::aluSrl, exePkg::aluSra,
                   exePkg::aluOr, exePkg::aluAnd};
        stOps  = '{exePkg::memSb, exePkg::memSh, exePkg::memSw};
        ldOps  = '{exePkg::memLb, exePkg::memLbu, exePkg::memLh, exePkg::memLhu,
                   exePkg::memLw};
        nrst = 1'b1;
        setIdle();
        #1 nrst = 1'b0;
        repeat (10) @(posedge clk);
        #2 nrst = 1'b1;
        // fill pattern built from the whole word index
        for (int i = 0; i < dmemWords; i++)
            issueMem(exePkg::memSw, i * 4, (i * 32'h9e37_79b9) ^ 32'h5a5a_0000);
        endTest("fill");
        resetTest();
        aluTest();
        branchTest();
        mulDivTest();
        memTest();
        misalignTest();
        $display("tests run %0d, tests failed %0d, assertion failures %0d",
                 testsRun, testsFailed, dut_i.chk_i.failCount);
        if (testsFailed == 0 && dut_i.chk_i.failCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb.f */
design/exePkg.sv
design/alu.sv
design/branchUnit.sv
design/mulDiv.sv
design/memWrap.sv
design/exeStage.sv
verification/exeStage_assert.sv
verification/exeStageTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exeStageTb
LOG       ?= sim.log
OBJDIR    ?= obj_dir
FLIST     ?= tb.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
